// ==== Bender.yml ====
package:
  name: arm_ctrl

sources:
  - hw/armIsaPkg.sv
  - hw/pipeCtrlPkg.sv
  - hw/instrDecoder.sv
  - hw/condUnit.sv
  - hw/pipeController.sv
  - hw/hazardUnit.sv
  - hw/armCtrlTop.sv
  - target: simulation
    files:
      - bench/armCtrl_props.sv
      - bench/armCtrlTb.sv

// ==== bench/armCtrlTb.sv ====
module armCtrlTb import armIsaPkg::*, pipeCtrlPkg::*; ();

  localparam int Period        = 100;
  localparam int DriveDelay    = 10;
  localparam int ResetCycles   = 5;
  localparam int NumCondTrials = 24;

  // Cycle budget of each sequence for the watchdog
  localparam int DecodeCycles  = 37 * 4 + 3;
  localparam int CondCycles    = NumCondTrials * 3 + 3;
  localparam int FlagCycles    = 12;
  localparam int TimingCycles  = 14;
  localparam int HazardCycles  = 24;
  localparam int MemCycles     = 16;
  localparam int TotalCycles   = ResetCycles + 2 + DecodeCycles + CondCycles + FlagCycles +
                                 TimingCycles + HazardCycles + MemCycles;
  localparam int MarginCycles  = 20;

  localparam logic [31:0] Bubble = 32'hF000_0000;  // AND r0 with cond NV

  logic        clk;
  logic        arstN;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic        memBusy;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  dpOpcodeT    aluControlE;
  logic        branchTakenE;
  logic        carryInE;
  logic        memWriteM;
  logic        memToRegW;
  logic        regWriteW;
  logic        pcSrcW;
  fwdSelT      forwardAE;
  fwdSelT      forwardBE;
  logic        stallF;
  logic        stallD;
  logic        flushD;

  integer      seed = 32'ha9a9_7a59;
  logic [31:0] rnd;
  logic [3:0]  flagModel;  // {N, Z, C, V} as the flag rule predicts
  logic [3:0]  cond;
  dpOpcodeT    op;
  logic        immFlag;
  string       testName;
  int          tbErrors;
  int          errBase;
  int          testsRun;
  int          testsFailed;
  int          errTotal;

  armCtrlTop #(.RegIdxW(RegIdxW)) armCtrlTop_inst (
    .clk          (clk),
    .arstN        (arstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .memBusy      (memBusy),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .carryInE     (carryInE),
    .memWriteM    (memWriteM),
    .memToRegW    (memToRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD)
  );

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  function automatic logic [31:0] dpInstr(input logic [3:0] c, input dpOpcodeT opc,
                                          input logic s, input logic imm, input logic [3:0] rn,
                                          input logic [3:0] rd, input logic [3:0] rm);
    return {c, 2'b00, imm, opc, s, rn, rd, 8'h00, rm};  // Bit 4 clear so no register shift
  endfunction

  function automatic logic [31:0] memInstr(input logic load, input logic [3:0] rd,
                                           input logic [3:0] rn);
    return {4'hE, 2'b01, 1'b0, 4'b1100, load, rn, rd, 12'h004};
  endfunction

  function automatic logic [31:0] branchInstr(input logic [3:0] c);
    return {c, 4'b1010, 24'h000010};
  endfunction

  // ARM condition table on {N, Z, C, V}
  function automatic logic condPass(input logic [3:0] c, input logic [3:0] f);
    logic n;
    logic z;
    logic cy;
    logic v;
    {n, z, cy, v} = f;
    case (c)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return cy;
      4'h3: return !cy;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return cy && !z;
      4'h9: return !cy || z;
      4'hA: return n == v;
      4'hB: return n != v;
      4'hC: return !z && (n == v);
      4'hD: return z || (n != v);
      4'hE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #DriveDelay;
  endtask

  task automatic drain(input int n);
    instrD = Bubble;
    repeat (n) nextCycle();
  endtask

  task automatic checkEq(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("Mismatch in %s, %s: expected %0h, actual %0h",
               testName, what, expected, actual);
      tbErrors++;
    end
  endtask

  task automatic beginTest(input string name);
    testName = name;
    errBase  = tbErrors + armCtrlTop_inst.armCtrlProps_inst.failCount;
  endtask

  task automatic endTest();
    int delta;
    delta = tbErrors + armCtrlTop_inst.armCtrlProps_inst.failCount - errBase;
    testsRun++;
    if (delta != 0)
      testsFailed++;
    $display("Test %s finished with %0d errors", testName, delta);
  endtask

  // One instruction through E and on to W with bubbles behind it
  task automatic decodeOne(input logic [31:0] instr, input logic [1:0] expRegSrc,
                           input logic [1:0] expImmSrc, input dpOpcodeT expCtl,
                           input logic expSrc, input logic expWrite, input logic expLoad,
                           input logic expPc);
    instrD = instr;
    @(negedge clk);
    checkEq("regSrcD", expRegSrc, regSrcD);
    checkEq("immSrcD", expImmSrc, immSrcD);
    nextCycle();
    instrD = Bubble;
    @(negedge clk);
    checkEq("aluControlE", expCtl, aluControlE);
    checkEq("aluSrcE", expSrc, aluSrcE);
    nextCycle();
    nextCycle();
    @(negedge clk);
    checkEq("regWriteW", expWrite, regWriteW);
    checkEq("memToRegW", expLoad, memToRegW);
    checkEq("pcSrcW", expPc, pcSrcW);
    nextCycle();
  endtask

  initial begin
    arstN     = 1'b0;
    instrD    = Bubble;
    aluFlagsE = 4'h0;
    memBusy   = 1'b0;
    tbErrors  = 0;
    testsRun  = 0;
    testsFailed = 0;
    flagModel = 4'h0;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay arstN = 1'b1;

    beginTest("reset");
    @(negedge clk);
    checkEq("regWriteW", 0, regWriteW);
    checkEq("memWriteM", 0, memWriteM);
    checkEq("branchTakenE", 0, branchTakenE);
    checkEq("carryInE", 0, carryInE);
    nextCycle();
    endTest();

    beginTest("decode");
    for (int i = 0; i < 32; i++) begin
      op      = dpOpcodeT'(i[3:0]);
      immFlag = i[4];
      // TST, TEQ, CMP and CMN are 10xx and never write
      decodeOne(dpInstr(4'hE, op, 1'b0, immFlag, 4'd1, 4'd2, 4'd3), 2'b00, 2'b00, op,
                immFlag, op[3:2] != 2'b10, 1'b0, 1'b0);
    end
    // MOV pc writes the PC
    decodeOne(dpInstr(4'hE, opMov, 1'b0, 1'b0, 4'd0, 4'hF, 4'd3), 2'b00, 2'b00, opMov,
              1'b0, 1'b1, 1'b0, 1'b1);
    decodeOne(memInstr(1'b1, 4'd4, 4'd1), 2'b00, 2'b01, opAdd, 1'b1, 1'b1, 1'b1, 1'b0);
    decodeOne(memInstr(1'b0, 4'd4, 4'd1), 2'b10, 2'b01, opAdd, 1'b1, 1'b0, 1'b0, 1'b0);
    decodeOne(branchInstr(4'hE), 2'b01, 2'b10, opAdd, 1'b1, 1'b0, 1'b0, 1'b1);
    decodeOne(branchInstr(4'hF), 2'b01, 2'b10, opAdd, 1'b1, 1'b0, 1'b0, 1'b0);
    endTest();

    beginTest("conditions");
    drain(3);
    repeat (NumCondTrials) begin
      rnd    = $random(seed);
      cond   = rnd[7:4];
      instrD = dpInstr(4'hE, opAdd, 1'b1, 1'b0, 4'd1, 4'd1, 4'd2);  // ADDS sets all flags
      nextCycle();
      aluFlagsE = rnd[3:0];
      flagModel = rnd[3:0];
      instrD    = branchInstr(cond);
      nextCycle();
      instrD = Bubble;
      @(negedge clk);
      checkEq("branchTakenE", condPass(cond, flagModel), branchTakenE);
      nextCycle();
    end
    endTest();

    beginTest("flags");
    drain(3);
    rnd    = $random(seed);
    instrD = dpInstr(4'hE, opAdd, 1'b1, 1'b0, 4'd1, 4'd1, 4'd2);
    nextCycle();
    aluFlagsE = rnd[3:0];
    flagModel = rnd[3:0];
    instrD    = Bubble;
    nextCycle();
    @(negedge clk);
    checkEq("carryInE after ADDS", flagModel[1], carryInE);
    nextCycle();
    rnd    = $random(seed);
    instrD = dpInstr(4'hE, opAnd, 1'b1, 1'b0, 4'd1, 4'd1, 4'd2);  // Logical op writes N and Z only
    nextCycle();
    aluFlagsE      = {rnd[3:2], ~flagModel[1], rnd[0]};
    flagModel[3:2] = rnd[3:2];
    instrD         = branchInstr(4'h0);
    nextCycle();
    instrD = Bubble;
    @(negedge clk);
    checkEq("carryInE after ANDS", flagModel[1], carryInE);
    checkEq("branchTakenE on EQ", condPass(4'h0, flagModel), branchTakenE);
    nextCycle();
    endTest();

    beginTest("timing");
    drain(3);
    instrD = dpInstr(4'hE, opAdd, 1'b0, 1'b0, 4'd1, 4'd7, 4'd2);
    for (int k = 1; k <= 4; k++) begin
      nextCycle();
      instrD = Bubble;
      @(negedge clk);
      checkEq("regWriteW passing", k == 3, regWriteW);
    end
    nextCycle();
    cond   = flagModel[2] ? 4'h1 : 4'h0;  // Fails on the stored Z
    instrD = dpInstr(cond, opAdd, 1'b0, 1'b0, 4'd1, 4'd7, 4'd2);
    for (int k = 1; k <= 4; k++) begin
      nextCycle();
      instrD = Bubble;
      @(negedge clk);
      checkEq("regWriteW failing", 0, regWriteW);
    end
    nextCycle();
    endTest();

    beginTest("hazards");
    drain(3);
    instrD = memInstr(1'b1, 4'd3, 4'd1);  // LDR r3
    nextCycle();
    instrD = dpInstr(4'hE, opAdd, 1'b0, 1'b0, 4'd3, 4'd4, 4'd2);
    @(negedge clk);
    checkEq("stallD load use", 1, stallD);
    checkEq("stallF load use", 1, stallF);
    nextCycle();  // D holds the dependent ADD
    @(negedge clk);
    checkEq("stallD released", 0, stallD);
    nextCycle();
    instrD = Bubble;
    @(negedge clk);
    checkEq("forwardAE load result", fwdWb, forwardAE);
    nextCycle();
    drain(3);
    instrD = dpInstr(4'hE, opAdd, 1'b0, 1'b0, 4'd1, 4'd5, 4'd2);
    nextCycle();
    instrD = dpInstr(4'hE, opAdd, 1'b0, 1'b0, 4'd5, 4'd6, 4'd5);
    nextCycle();
    instrD = Bubble;
    @(negedge clk);
    checkEq("forwardAE", fwdMem, forwardAE);
    checkEq("forwardBE", fwdMem, forwardBE);
    nextCycle();
    drain(2);
    instrD = branchInstr(4'hE);
    nextCycle();
    instrD = Bubble;
    @(negedge clk);
    checkEq("branchTakenE", 1, branchTakenE);
    checkEq("flushD", 1, flushD);
    checkEq("stallF PC write", 1, stallF);
    nextCycle();
    drain(4);
    endTest();

    beginTest("memory stall");
    drain(3);
    instrD = dpInstr(4'hE, opAdd, 1'b0, 1'b0, 4'd1, 4'd8, 4'd2);
    nextCycle();
    instrD = memInstr(1'b0, 4'd9, 4'd1);  // STR r9
    nextCycle();
    drain(1);
    memBusy = 1'b1;
    @(negedge clk);
    checkEq("memWriteM before stall", 1, memWriteM);
    repeat (3) begin
      nextCycle();
      @(negedge clk);
      checkEq("memWriteM held", 1, memWriteM);
      checkEq("regWriteW during stall", 0, regWriteW);
    end
    nextCycle();
    memBusy = 1'b0;
    drain(3);
    endTest();

    errTotal = tbErrors + armCtrlTop_inst.armCtrlProps_inst.failCount;
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion errors",
             testsRun, testsFailed, tbErrors, armCtrlTop_inst.armCtrlProps_inst.failCount);
    if (errTotal == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial begin
    #((TotalCycles + MarginCycles) * Period);
    $display("Timeout: the test sequences did not finish in time");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== bench/armCtrl_props.sv ====
module armCtrlProps import pipeCtrlPkg::*; #(
  parameter int RegIdxW = pipeCtrlPkg::RegIdxW
) (
  input logic               clk,
  input logic               arstN,
  input logic [31:0]        instrD,
  input logic               memBusy,
  input logic               branchTakenE,
  input logic               flushD,
  input logic               stallD,
  input logic               regWriteW,
  input logic               memWriteM,
  input logic               regWriteM,
  input logic [RegIdxW-1:0] wa3M,
  input logic [RegIdxW-1:0] ra1E,
  input fwdSelT             forwardAE
);

  int unsigned failCount = 0;

  // TST, TEQ, CMP and CMN only set flags
  compareNoWrite: assert property (@(posedge clk) disable iff (!arstN)
    (instrD[27:26] == 2'b00 && instrD[24:23] == 2'b10 && !stallD && !memBusy)
      ##1 !memBusy [*2] |=> !regWriteW)
    else begin failCount++; $error("Compare instruction wrote a register in Writeback"); end

  nvBranchNotTaken: assert property (@(posedge clk) disable iff (!arstN)
    (!memBusy && instrD[31:28] == 4'hF && instrD[27:26] == 2'b10) |=> !branchTakenE)
    else begin failCount++; $error("Branch with condition NV was taken"); end

  takenBranchFlush: assert property (@(posedge clk) disable iff (!arstN)
    (branchTakenE && !memBusy) |-> flushD)
    else begin failCount++; $error("Taken branch did not flush Decode"); end

  loadUseOneCycle: assert property (@(posedge clk) disable iff (!arstN)
    (stallD && !memBusy) |=> (!stallD || memBusy))
    else begin failCount++; $error("Load-use stall lasted more than one cycle"); end

  busyHoldsMem: assert property (@(posedge clk) disable iff (!arstN)
    memBusy |=> ($stable(memWriteM) && !regWriteW))
    else begin failCount++; $error("Memory stage moved or Writeback wrote while busy"); end

  forwardFromMem: assert property (@(posedge clk) disable iff (!arstN)
    (regWriteM && wa3M == ra1E) |-> forwardAE == fwdMem)
    else begin failCount++; $error("Operand A not forwarded from Memory"); end

endmodule

bind armCtrlTop armCtrlProps #(.RegIdxW(RegIdxW)) armCtrlProps_inst (
  .clk          (clk),
  .arstN        (arstN),
  .instrD       (instrD),
  .memBusy      (memBusy),
  .branchTakenE (branchTakenE),
  .flushD       (flushD),
  .stallD       (stallD),
  .regWriteW    (regWriteW),
  .memWriteM    (memWriteM),
  .regWriteM    (regWriteM),
  .wa3M         (wa3M),
  .ra1E         (ra1E),
  .forwardAE    (forwardAE)
);

// ==== build.f ====
hw/armIsaPkg.sv
hw/pipeCtrlPkg.sv
hw/instrDecoder.sv
hw/condUnit.sv
hw/pipeController.sv
hw/hazardUnit.sv
hw/armCtrlTop.sv
bench/armCtrl_props.sv
bench/armCtrlTb.sv

// ==== hw/armCtrlTop.sv ====
module armCtrlTop import armIsaPkg::*, pipeCtrlPkg::*; #(
  parameter int RegIdxW = pipeCtrlPkg::RegIdxW
) (
  input  logic        clk,
  input  logic        arstN,
  input  logic [31:0] instrD,
  input  logic [3:0]  aluFlagsE,
  input  logic        memBusy,
  output logic [1:0]  regSrcD,
  output logic [1:0]  immSrcD,
  output logic        aluSrcE,
  output dpOpcodeT    aluControlE,
  output logic        branchTakenE,
  output logic        carryInE,
  output logic        memWriteM,
  output logic        memToRegW,
  output logic        regWriteW,
  output logic        pcSrcW,
  output fwdSelT      forwardAE,
  output fwdSelT      forwardBE,
  output logic        stallF,
  output logic        stallD,
  output logic        flushD
);

  logic               aluSrcD;
  logic               memToRegD;
  logic               regWriteD;
  logic               memWriteD;
  logic               branchD;
  dpOpcodeT           aluControlD;
  logic [1:0]         flagWriteD;
  logic               noWriteD;
  logic               pcSrcD;
  logic [RegIdxW-1:0] rdD;
  logic [RegIdxW-1:0] ra1D;
  logic [RegIdxW-1:0] ra2D;
  logic [RegIdxW-1:0] ra1E;
  logic [RegIdxW-1:0] ra2E;
  logic [RegIdxW-1:0] wa3E;
  logic [RegIdxW-1:0] wa3M;
  logic [RegIdxW-1:0] wa3W;
  logic               memToRegE;
  logic               regWriteM;
  logic               pcWrPendingF;
  logic               stallE;
  logic               stallM;
  logic               flushE;
  logic               flushW;

  // Branch reads PC, STR reads Rd as its store data
  assign ra1D = regSrcD[0] ? RegIdxW'(15) : RegIdxW'(instrD[RnHi:RnLo]);
  assign ra2D = regSrcD[1] ? RegIdxW'(instrD[RdHi:RdLo]) : RegIdxW'(instrD[RmHi:RmLo]);
  assign rdD  = RegIdxW'(instrD[RdHi:RdLo]);

  instrDecoder instrDecoder_inst (
    .instrD      (instrD),
    .instrClass  (),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluSrcD     (aluSrcD),
    .memToRegD   (memToRegD),
    .regWriteD   (regWriteD),
    .memWriteD   (memWriteD),
    .branchD     (branchD),
    .aluControlD (aluControlD),
    .flagWriteD  (flagWriteD),
    .noWriteD    (noWriteD),
    .pcSrcD      (pcSrcD)
  );

  pipeController #(.RegIdxW(RegIdxW)) pipeController_inst (
    .clk          (clk),
    .arstN        (arstN),
    .aluSrcD      (aluSrcD),
    .memToRegD    (memToRegD),
    .regWriteD    (regWriteD),
    .memWriteD    (memWriteD),
    .branchD      (branchD),
    .aluControlD  (aluControlD),
    .flagWriteD   (flagWriteD),
    .noWriteD     (noWriteD),
    .pcSrcD       (pcSrcD),
    .rdD          (rdD),
    .ra1D         (ra1D),
    .ra2D         (ra2D),
    .condD        (condCodeT'(instrD[CondHi:CondLo])),
    .aluFlagsE    (aluFlagsE),
    .stallE       (stallE),
    .stallM       (stallM),
    .flushE       (flushE),
    .flushW       (flushW),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .carryInE     (carryInE),
    .memToRegE    (memToRegE),
    .memWriteM    (memWriteM),
    .memToRegM    (),
    .regWriteM    (regWriteM),
    .memToRegW    (memToRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .wa3E         (wa3E),
    .wa3M         (wa3M),
    .wa3W         (wa3W),
    .ra1E         (ra1E),
    .ra2E         (ra2E),
    .pcWrPendingF (pcWrPendingF)
  );

  hazardUnit #(.RegIdxW(RegIdxW)) hazardUnit_inst (
    .ra1D         (ra1D),
    .ra2D         (ra2D),
    .ra1E         (ra1E),
    .ra2E         (ra2E),
    .wa3E         (wa3E),
    .wa3M         (wa3M),
    .wa3W         (wa3W),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .memToRegE    (memToRegE),
    .branchTakenE (branchTakenE),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW),
    .memBusy      (memBusy),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .stallF       (stallF),
    .stallD       (stallD),
    .stallE       (stallE),
    .stallM       (stallM),
    .flushD       (flushD),
    .flushE       (flushE),
    .flushW       (flushW)
  );

endmodule

// ==== hw/armIsaPkg.sv ====
package armIsaPkg;

  // Bits 27:26 of the instruction word
  typedef enum logic [1:0] {
    dataProc  = 2'b00,
    memory    = 2'b01,
    branch    = 2'b10,
    undefined = 2'b11
  } instrClassT;

  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opAdc = 4'b0101,
    opSbc = 4'b0110,
    opRsc = 4'b0111,
    opTst = 4'b1000,
    opTeq = 4'b1001,
    opCmp = 4'b1010,
    opCmn = 4'b1011,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opBic = 4'b1110,
    opMvn = 4'b1111
  } dpOpcodeT;

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl, condNv
  } condCodeT;

  localparam int CondHi      = 31;
  localparam int CondLo      = 28;
  localparam int ClassHi     = 27;
  localparam int ClassLo     = 26;
  localparam int ImmBit      = 25;  // I flag
  localparam int OpHi        = 24;
  localparam int OpLo        = 21;
  localparam int SBit        = 20;  // S for data processing, L for load/store
  localparam int RnHi        = 19;
  localparam int RnLo        = 16;
  localparam int RdHi        = 15;
  localparam int RdLo        = 12;
  localparam int ShiftRegBit = 4;   // Shift amount taken from a register
  localparam int RmHi        = 3;
  localparam int RmLo        = 0;

endpackage

// ==== hw/condUnit.sv ====
module condUnit import armIsaPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic       enable,
  input  condCodeT   condE,
  input  logic [3:0] aluFlagsE,
  input  logic [1:0] flagWriteE,
  output logic       condExE,
  output logic       carryInE
);

  logic [3:0] flags;  // {N, Z, C, V}
  logic       neg;
  logic       zero;
  logic       carry;
  logic       overflow;
  logic       ge;

  assign {neg, zero, carry, overflow} = flags;
  assign ge = (neg == overflow);

  always_comb begin
    case (condE)
      condEq:  condExE = zero;
      condNe:  condExE = ~zero;
      condCs:  condExE = carry;
      condCc:  condExE = ~carry;
      condMi:  condExE = neg;
      condPl:  condExE = ~neg;
      condVs:  condExE = overflow;
      condVc:  condExE = ~overflow;
      condHi:  condExE = carry & ~zero;
      condLs:  condExE = ~carry | zero;
      condGe:  condExE = ge;
      condLt:  condExE = ~ge;
      condGt:  condExE = ~zero & ge;
      condLe:  condExE = zero | ~ge;
      condAl:  condExE = 1'b1;
      default: condExE = 1'b0;  // NV never executes
    endcase
  end

  // Written as the instruction leaves Execute
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= 4'b0000;
    end else if (enable) begin
      if (condExE && flagWriteE[1])
        flags[3:2] <= aluFlagsE[3:2];
      if (condExE && flagWriteE[0])
        flags[1:0] <= aluFlagsE[1:0];
    end
  end

  assign carryInE = carry;  // For ADC, SBC and RSC

endmodule

// ==== hw/hazardUnit.sv ====
module hazardUnit import pipeCtrlPkg::*; #(
  parameter int RegIdxW = pipeCtrlPkg::RegIdxW
) (
  input  logic [RegIdxW-1:0] ra1D,
  input  logic [RegIdxW-1:0] ra2D,
  input  logic [RegIdxW-1:0] ra1E,
  input  logic [RegIdxW-1:0] ra2E,
  input  logic [RegIdxW-1:0] wa3E,
  input  logic [RegIdxW-1:0] wa3M,
  input  logic [RegIdxW-1:0] wa3W,
  input  logic               regWriteM,
  input  logic               regWriteW,
  input  logic               memToRegE,
  input  logic               branchTakenE,
  input  logic               pcWrPendingF,
  input  logic               pcSrcW,
  input  logic               memBusy,
  output fwdSelT             forwardAE,
  output fwdSelT             forwardBE,
  output logic               stallF,
  output logic               stallD,
  output logic               stallE,
  output logic               stallM,
  output logic               flushD,
  output logic               flushE,
  output logic               flushW
);

  logic ldStall;

  // Newest producer wins
  function automatic fwdSelT pickFwd(input logic [RegIdxW-1:0] src);
    if (regWriteM && (src == wa3M))
      return fwdMem;
    else if (regWriteW && (src == wa3W))
      return fwdWb;
    else
      return fwdNone;
  endfunction

  always_comb begin
    forwardAE = pickFwd(ra1E);
    forwardBE = pickFwd(ra2E);
  end

  // Load result not ready before M
  assign ldStall = memToRegE & ((wa3E == ra1D) | (wa3E == ra2D));

  assign stallF = ldStall | pcWrPendingF | memBusy;
  assign stallD = ldStall | memBusy;
  assign stallE = memBusy;
  assign stallM = memBusy;

  assign flushD = (pcWrPendingF | pcSrcW | branchTakenE) & ~memBusy;
  assign flushE = ldStall | branchTakenE;  // Ignored while E holds
  assign flushW = memBusy;                 // Bubble while M waits on memory

endmodule

// ==== hw/instrDecoder.sv ====
module instrDecoder import armIsaPkg::*; (
  input  logic [31:0] instrD,
  output instrClassT  instrClass,
  output logic [1:0]  regSrcD,
  output logic [1:0]  immSrcD,
  output logic        aluSrcD,
  output logic        memToRegD,
  output logic        regWriteD,
  output logic        memWriteD,
  output logic        branchD,
  output dpOpcodeT    aluControlD,
  output logic [1:0]  flagWriteD,
  output logic        noWriteD,
  output logic        pcSrcD
);

  logic [9:0] controls;
  logic       aluOpD;
  logic       sBit;
  logic       arithOp;
  dpOpcodeT   opcode;

  assign instrClass = instrClassT'(instrD[ClassHi:ClassLo]);
  assign opcode     = dpOpcodeT'(instrD[OpHi:OpLo]);
  assign sBit       = instrD[SBit];

  // Main decoder
  // {regSrc, immSrc, aluSrc, memToReg, regWrite, memWrite, branch, aluOp}
  always_comb begin
    case (instrClass)
      dataProc: begin
        if (instrD[ImmBit])
          controls = 10'b00_00_1_0_1_0_0_1;
        else if (instrD[ShiftRegBit])
          controls = 10'b00_00_0_0_0_0_0_0;  // Shift by register or multiply
        else
          controls = 10'b00_00_0_0_1_0_0_1;
      end
      memory: begin
        if (instrD[ImmBit])
          controls = 10'b00_00_0_0_0_0_0_0;  // Register offset not supported
        else if (instrD[SBit])
          controls = 10'b00_01_1_1_1_0_0_0;  // LDR
        else
          controls = 10'b10_01_1_0_0_1_0_0;  // STR reads Rd as second source
      end
      branch:  controls = 10'b01_10_1_0_0_0_1_0;  // PC as first source
      default: controls = 10'b00_00_0_0_0_0_0_0;
    endcase
  end

  assign {regSrcD, immSrcD, aluSrcD, memToRegD,
          regWriteD, memWriteD, branchD, aluOpD} = controls;

  // ALU decoder
  assign arithOp = opcode inside {opAdd, opSub, opRsb, opAdc, opSbc, opRsc, opCmp, opCmn};

  always_comb begin
    if (aluOpD) begin
      aluControlD   = opcode;
      flagWriteD[1] = sBit;            // N and Z
      flagWriteD[0] = sBit & arithOp;  // C and V only from the adder
    end else begin
      aluControlD = opAdd;  // Address and branch target
      flagWriteD  = 2'b00;
    end
  end

  // Compare and test set flags only
  assign noWriteD = aluOpD & (opcode inside {opTst, opTeq, opCmp, opCmn});

  assign pcSrcD = branchD |
                  (regWriteD & ~noWriteD & (instrD[RdHi:RdLo] == 4'hF));

endmodule

// ==== hw/pipeController.sv ====
module pipeController import armIsaPkg::*; #(
  parameter int RegIdxW = pipeCtrlPkg::RegIdxW
) (
  input  logic               clk,
  input  logic               arstN,
  input  logic               aluSrcD,
  input  logic               memToRegD,
  input  logic               regWriteD,
  input  logic               memWriteD,
  input  logic               branchD,
  input  dpOpcodeT           aluControlD,
  input  logic [1:0]         flagWriteD,
  input  logic               noWriteD,
  input  logic               pcSrcD,
  input  logic [RegIdxW-1:0] rdD,
  input  logic [RegIdxW-1:0] ra1D,
  input  logic [RegIdxW-1:0] ra2D,
  input  condCodeT           condD,
  input  logic [3:0]         aluFlagsE,
  input  logic               stallE,
  input  logic               stallM,
  input  logic               flushE,
  input  logic               flushW,
  output logic               aluSrcE,
  output dpOpcodeT           aluControlE,
  output logic               branchTakenE,
  output logic               carryInE,
  output logic               memToRegE,
  output logic               memWriteM,
  output logic               memToRegM,
  output logic               regWriteM,
  output logic               memToRegW,
  output logic               regWriteW,
  output logic               pcSrcW,
  output logic [RegIdxW-1:0] wa3E,
  output logic [RegIdxW-1:0] wa3M,
  output logic [RegIdxW-1:0] wa3W,
  output logic [RegIdxW-1:0] ra1E,
  output logic [RegIdxW-1:0] ra2E,
  output logic               pcWrPendingF
);

  logic       regWriteE;
  logic       memWriteE;
  logic       branchE;
  logic       pcSrcE;
  logic       noWriteE;
  logic [1:0] flagWriteE;
  condCodeT   condE;
  logic       condExE;
  logic       regWriteGatedE;
  logic       memWriteGatedE;
  logic       pcSrcGatedE;
  logic       pcSrcM;

  // Execute control, a flush inserts a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {regWriteE, memWriteE, memToRegE, branchE, pcSrcE, noWriteE} <= 6'b0;
      flagWriteE <= 2'b00;
    end else if (!stallE) begin
      if (flushE) begin
        {regWriteE, memWriteE, memToRegE, branchE, pcSrcE, noWriteE} <= 6'b0;
        flagWriteE <= 2'b00;
      end else begin
        {regWriteE, memWriteE, memToRegE, branchE, pcSrcE, noWriteE} <=
          {regWriteD, memWriteD, memToRegD, branchD, pcSrcD, noWriteD};
        flagWriteE <= flagWriteD;
      end
    end
  end

  // Execute selects and register indices
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      aluSrcE     <= 1'b0;
      aluControlE <= opAnd;
      condE       <= condEq;
      wa3E        <= '0;
      ra1E        <= '0;
      ra2E        <= '0;
    end else if (!stallE) begin
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
      condE       <= condD;
      wa3E        <= rdD;
      ra1E        <= ra1D;
      ra2E        <= ra2D;
    end
  end

  condUnit condUnit_inst (
    .clk        (clk),
    .arstN      (arstN),
    .enable     (~stallE),
    .condE      (condE),
    .aluFlagsE  (aluFlagsE),
    .flagWriteE (flagWriteE),
    .condExE    (condExE),
    .carryInE   (carryInE)
  );

  assign branchTakenE   = branchE & condExE;
  assign regWriteGatedE = regWriteE & condExE & ~noWriteE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memWriteM, memToRegM, regWriteM, pcSrcM} <= 4'b0;
      wa3M <= '0;
    end else if (!stallM) begin
      {memWriteM, memToRegM, regWriteM, pcSrcM} <=
        {memWriteGatedE, memToRegE, regWriteGatedE, pcSrcGatedE};
      wa3M <= wa3E;
    end
  end

  // Writeback never stalls
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memToRegW, regWriteW, pcSrcW} <= 3'b0;
      wa3W <= '0;
    end else begin
      if (flushW)
        {memToRegW, regWriteW, pcSrcW} <= 3'b0;
      else
        {memToRegW, regWriteW, pcSrcW} <= {memToRegM, regWriteM, pcSrcM};
      wa3W <= wa3M;
    end
  end

  // Ungated in E, resolved once the condition is known in M
  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;

endmodule

// ==== hw/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

  // Source of an operand in Execute
  typedef enum logic [1:0] {
    fwdNone = 2'b00,  // Register file read
    fwdWb   = 2'b01,  // Result in Writeback
    fwdMem  = 2'b10   // ALU result in Memory
  } fwdSelT;

  // Register index width, r0 to r15
  localparam int RegIdxW = 4;

endpackage
